// ==== Makefile ====
TOP := tb_serv_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/bus_pkg.sv
rtl/bit_sequencer.sv
rtl/instr_decode.sv
rtl/serial_regfile.sv
rtl/serial_alu.sv
rtl/mem_buffer.sv
rtl/bus_arbiter.sv
rtl/serv_core_top.sv
tests/tb_serv_core.sv

// ==== rtl/bit_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "serv_config.svh"

module bit_sequencer
   import core_pkg::*, bus_pkg::*;
(
   input  wire           clk,
   input  wire           i_reset,
   input  wire ctrl_t    i_ctrl,
   input  wire mem_rsp_t i_ibus_rsp,
   input  wire           i_dbus_ack,
   output mem_req_t      o_ibus_req,
   output phase_e        o_phase,
   output logic          o_shift,
   output logic          o_last
);

   phase_e   phase_q;
   phase_e   phase_next;
   bit_cnt_t cnt_q;
   word_t    pc_q;
   logic     ibus_cyc_q;
   logic     mem_op;
   logic     instr_done;

   assign mem_op  = i_ctrl.is_load | i_ctrl.is_store;
   assign o_phase = phase_q;
   assign o_shift = (phase_q == PH_EXEC) | (phase_q == PH_WBACK);
   assign o_last  = o_shift & (cnt_q == 5'd31);

   always_comb begin
      phase_next = phase_q;
      instr_done = 1'b0;
      case (phase_q)
         PH_FETCH: begin
            if (i_ibus_rsp.ack) begin
               phase_next = PH_DECODE;
            end
         end
         PH_DECODE: begin
            phase_next = PH_EXEC;
         end
         PH_EXEC: begin
            if (o_last) begin
               phase_next = mem_op ? PH_MEM : PH_FETCH;
               instr_done = !mem_op;
            end
         end
         PH_MEM: begin
            if (i_dbus_ack) begin
               phase_next = i_ctrl.is_load ? PH_WBACK : PH_FETCH;
               instr_done = !i_ctrl.is_load;
            end
         end
         PH_WBACK: begin
            if (o_last) begin
               phase_next = PH_FETCH;
               instr_done = 1'b1;
            end
         end
         default: begin
            phase_next = PH_FETCH;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase_q    <= PH_FETCH;
         cnt_q      <= '0;
         pc_q       <= `SERV_RESET_PC;
         ibus_cyc_q <= 1'b0;
      end else begin
         phase_q <= phase_next;
         // Request stays up for the whole fetch, drops after the ack
         ibus_cyc_q <= (phase_next == PH_FETCH);
         if (o_shift) begin
            cnt_q <= cnt_q + 5'd1;
         end
         if (instr_done) begin
            pc_q <= pc_q + 32'd4;
         end
      end
   end

   always_comb begin
      o_ibus_req.cyc = ibus_cyc_q;
      o_ibus_req.we  = 1'b0;
      o_ibus_req.adr = pc_q;
      o_ibus_req.dat = '0;
   end

endmodule

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter
   import bus_pkg::*;
(
   input  wire           clk,
   input  wire           i_reset,
   input  wire mem_req_t i_ibus_req,
   output mem_rsp_t      o_ibus_rsp,
   input  wire mem_req_t i_dbus_req,
   output mem_rsp_t      o_dbus_rsp,
   output mem_req_t      o_mem_req,
   input  wire mem_rsp_t i_mem_rsp
);

   typedef enum logic [1:0] {
      GNT_NONE,
      GNT_IBUS,
      GNT_DBUS
   } grant_e;

   grant_e grant_q;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         grant_q <= GNT_NONE;
      end else if (grant_q == GNT_NONE) begin
         // Data side wins when both wait
         if (i_dbus_req.cyc) begin
            grant_q <= GNT_DBUS;
         end else if (i_ibus_req.cyc) begin
            grant_q <= GNT_IBUS;
         end
      end else if (i_mem_rsp.ack) begin
         grant_q <= GNT_NONE;
      end
   end

   always_comb begin
      o_mem_req  = '0;
      o_ibus_rsp = '0;
      o_dbus_rsp = '0;
      case (grant_q)
         GNT_IBUS: begin
            o_mem_req  = i_ibus_req;
            o_ibus_rsp = i_mem_rsp;
         end
         GNT_DBUS: begin
            o_mem_req  = i_dbus_req;
            o_dbus_rsp = i_mem_rsp;
         end
         default: begin
            o_mem_req = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

   import core_pkg::*;

   typedef struct packed {
      logic  cyc;
      logic  we;
      word_t adr;
      word_t dat;
   } mem_req_t;

   typedef struct packed {
      logic  ack;
      word_t rdt;
   } mem_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  bit_cnt_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   typedef enum logic [2:0] {
      PH_FETCH,
      PH_DECODE,
      PH_EXEC,
      PH_MEM,
      PH_WBACK
   } phase_e;

   // Decode results, valid from DECODE until the next fetch ack
   typedef struct packed {
      reg_addr_t rd_addr;
      reg_addr_t rs1_addr;
      reg_addr_t rs2_addr;
      alu_op_e   alu_op;
      logic      op_b_imm;
      logic      rd_wen;
      logic      is_load;
      logic      is_store;
   } ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decode
   import core_pkg::*, bus_pkg::*;
(
   input  wire           clk,
   input  wire mem_rsp_t i_ibus_rsp,
   input  wire phase_e   i_phase,
   input  wire           i_shift,
   output ctrl_t         o_ctrl,
   output logic          o_imm_bit
);

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [2:0] F3_ADD     = 3'b000;
   localparam logic [2:0] F3_WORD    = 3'b010;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_SUB     = 7'b0100000;

   word_t      instr_q;
   word_t      imm_q;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode    = instr_q[6:0];
   assign funct3    = instr_q[14:12];
   assign funct7    = instr_q[31:25];
   assign o_imm_bit = imm_q[0];

   always_ff @(posedge clk) begin
      if (i_ibus_rsp.ack) begin
         instr_q <= i_ibus_rsp.rdt;
      end
      if (i_phase == PH_DECODE) begin
         if (opcode == OPC_STORE) begin
            imm_q <= {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
         end else begin
            imm_q <= {{20{instr_q[31]}}, instr_q[31:20]};
         end
      end else if (i_shift && (i_phase == PH_EXEC)) begin
         // Sign bit refills from the top
         imm_q <= {imm_q[31], imm_q[31:1]};
      end
   end

   always_comb begin
      o_ctrl.rd_addr  = instr_q[11:7];
      o_ctrl.rs1_addr = instr_q[19:15];
      o_ctrl.rs2_addr = instr_q[24:20];
      o_ctrl.alu_op   = ALU_ADD;
      o_ctrl.op_b_imm = 1'b0;
      o_ctrl.rd_wen   = 1'b0;
      o_ctrl.is_load  = 1'b0;
      o_ctrl.is_store = 1'b0;
      case (opcode)
         OPC_OP_IMM: begin
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_wen   = 1'b1;
            case (funct3)
               F3_ADD:  o_ctrl.alu_op = ALU_ADD;
               F3_XOR:  o_ctrl.alu_op = ALU_XOR;
               F3_OR:   o_ctrl.alu_op = ALU_OR;
               F3_AND:  o_ctrl.alu_op = ALU_AND;
               default: o_ctrl.rd_wen = 1'b0;
            endcase
         end
         OPC_OP: begin
            o_ctrl.rd_wen = (funct7 == F7_BASE) ||
                            ((funct7 == F7_SUB) && (funct3 == F3_ADD));
            case (funct3)
               F3_ADD:  o_ctrl.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
               F3_XOR:  o_ctrl.alu_op = ALU_XOR;
               F3_OR:   o_ctrl.alu_op = ALU_OR;
               F3_AND:  o_ctrl.alu_op = ALU_AND;
               default: o_ctrl.rd_wen = 1'b0;
            endcase
         end
         OPC_LOAD: begin
            // Word access only, address is rs1 + imm
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_wen   = (funct3 == F3_WORD);
            o_ctrl.is_load  = (funct3 == F3_WORD);
         end
         OPC_STORE: begin
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.is_store = (funct3 == F3_WORD);
         end
         default: begin
            o_ctrl.rd_wen = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/mem_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_buffer
   import core_pkg::*, bus_pkg::*;
(
   input  wire           clk,
   input  wire phase_e   i_phase,
   input  wire           i_shift,
   input  wire ctrl_t    i_ctrl,
   input  wire           i_result_bit,
   input  wire           i_rs2_bit,
   input  wire mem_rsp_t i_dbus_rsp,
   output mem_req_t      o_dbus_req,
   output logic          o_rd_bit
);

   word_t adr_q;
   word_t dat_q;
   word_t ld_q;
   logic  mem_op;

   assign mem_op   = i_ctrl.is_load | i_ctrl.is_store;
   assign o_rd_bit = (i_phase == PH_WBACK) ? ld_q[0] : i_result_bit;

   always_ff @(posedge clk) begin
      if ((i_phase == PH_EXEC) && i_shift && mem_op) begin
         adr_q <= {i_result_bit, adr_q[31:1]};
         dat_q <= {i_rs2_bit, dat_q[31:1]};
      end
      if (i_dbus_rsp.ack && i_ctrl.is_load) begin
         ld_q <= i_dbus_rsp.rdt;
      end else if ((i_phase == PH_WBACK) && i_shift) begin
         ld_q <= {1'b0, ld_q[31:1]};
      end
   end

   // Request held for the whole MEM phase
   always_comb begin
      o_dbus_req.cyc = (i_phase == PH_MEM);
      o_dbus_req.we  = i_ctrl.is_store;
      o_dbus_req.adr = {adr_q[31:2], 2'b00};
      o_dbus_req.dat = dat_q;
   end

endmodule

`default_nettype wire

// ==== rtl/serial_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module serial_alu
   import core_pkg::*;
(
   input  wire          clk,
   input  wire          i_shift,
   input  wire          i_last,
   input  wire alu_op_e i_alu_op,
   input  wire          i_op_b_imm,
   input  wire          i_rs1_bit,
   input  wire          i_rs2_bit,
   input  wire          i_imm_bit,
   output logic         o_result_bit
);

   logic op_b;
   logic sub;
   logic b_eff;
   logic cin;
   logic cout;
   logic sum;
   logic carry_q;

   assign op_b  = i_op_b_imm ? i_imm_bit : i_rs2_bit;
   assign sub   = (i_alu_op == ALU_SUB);
   assign b_eff = op_b ^ sub;
   // Carry kept inverted for SUB, so a cleared flop means carry-in of one
   assign cin   = carry_q ^ sub;
   assign sum   = i_rs1_bit ^ b_eff ^ cin;
   assign cout  = (i_rs1_bit & b_eff) | (i_rs1_bit & cin) | (b_eff & cin);

   always_comb begin
      case (i_alu_op)
         ALU_XOR: o_result_bit = i_rs1_bit ^ op_b;
         ALU_OR:  o_result_bit = i_rs1_bit | op_b;
         ALU_AND: o_result_bit = i_rs1_bit & op_b;
         default: o_result_bit = sum;
      endcase
   end

   // Idle cycles before each pass also clear it
   always_ff @(posedge clk) begin
      if (!i_shift || i_last) begin
         carry_q <= 1'b0;
      end else begin
         carry_q <= cout ^ sub;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/serial_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "serv_config.svh"

module serial_regfile
   import core_pkg::*;
(
   input  wire         clk,
   input  wire phase_e i_phase,
   input  wire         i_shift,
   input  wire         i_last,
   input  wire ctrl_t  i_ctrl,
   input  wire         i_rd_bit,
   output logic        o_rs1_bit,
   output logic        o_rs2_bit
);

   word_t regs [`SERV_REG_COUNT];
   word_t rs1_q;
   word_t rs2_q;
   word_t wr_q;
   word_t wr_word;
   logic  wr_phase;
   logic  wr_en;

   // ALU ops write back in EXEC, loads in WBACK
   assign wr_phase = ((i_phase == PH_EXEC) && !i_ctrl.is_load && !i_ctrl.is_store) ||
                     ((i_phase == PH_WBACK) && i_ctrl.is_load);
   assign wr_en    = wr_phase & i_last & i_ctrl.rd_wen & (i_ctrl.rd_addr != 5'd0);
   assign wr_word  = {i_rd_bit, wr_q[31:1]};

   assign o_rs1_bit = rs1_q[0];
   assign o_rs2_bit = rs2_q[0];

   always_ff @(posedge clk) begin
      if (i_phase == PH_DECODE) begin
         // x0 is never written, force zero on read
         rs1_q <= (i_ctrl.rs1_addr == 5'd0) ? '0 : regs[i_ctrl.rs1_addr];
         rs2_q <= (i_ctrl.rs2_addr == 5'd0) ? '0 : regs[i_ctrl.rs2_addr];
      end else if (i_shift) begin
         rs1_q <= {1'b0, rs1_q[31:1]};
         rs2_q <= {1'b0, rs2_q[31:1]};
      end
      if (i_shift) begin
         wr_q <= wr_word;
      end
      if (wr_en) begin
         regs[i_ctrl.rd_addr] <= wr_word;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/serv_config.svh ====
`ifndef SERV_CONFIG_SVH
`define SERV_CONFIG_SVH

// Address of the first fetch after reset
`define SERV_RESET_PC 32'h0000_0000

// Register file depth, x0 included
`define SERV_REG_COUNT 32

`endif

// ==== rtl/serv_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module serv_core_top
   import core_pkg::*, bus_pkg::*;
(
   input  wire           clk,
   input  wire           i_reset,
   output mem_req_t      o_mem_req,
   input  wire mem_rsp_t i_mem_rsp
);

   mem_req_t ibus_req;
   mem_rsp_t ibus_rsp;
   mem_req_t dbus_req;
   mem_rsp_t dbus_rsp;
   ctrl_t    ctrl;
   phase_e   phase;
   logic     shift;
   logic     last;
   logic     imm_bit;
   logic     rs1_bit;
   logic     rs2_bit;
   logic     result_bit;
   logic     rd_bit;

   bit_sequencer bit_sequencer_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ctrl     (ctrl),
      .i_ibus_rsp (ibus_rsp),
      .i_dbus_ack (dbus_rsp.ack),
      .o_ibus_req (ibus_req),
      .o_phase    (phase),
      .o_shift    (shift),
      .o_last     (last)
   );

   instr_decode instr_decode_i (
      .clk        (clk),
      .i_ibus_rsp (ibus_rsp),
      .i_phase    (phase),
      .i_shift    (shift),
      .o_ctrl     (ctrl),
      .o_imm_bit  (imm_bit)
   );

   serial_regfile serial_regfile_i (
      .clk       (clk),
      .i_phase   (phase),
      .i_shift   (shift),
      .i_last    (last),
      .i_ctrl    (ctrl),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu serial_alu_i (
      .clk          (clk),
      .i_shift      (shift),
      .i_last       (last),
      .i_alu_op     (ctrl.alu_op),
      .i_op_b_imm   (ctrl.op_b_imm),
      .i_rs1_bit    (rs1_bit),
      .i_rs2_bit    (rs2_bit),
      .i_imm_bit    (imm_bit),
      .o_result_bit (result_bit)
   );

   mem_buffer mem_buffer_i (
      .clk          (clk),
      .i_phase      (phase),
      .i_shift      (shift),
      .i_ctrl       (ctrl),
      .i_result_bit (result_bit),
      .i_rs2_bit    (rs2_bit),
      .i_dbus_rsp   (dbus_rsp),
      .o_dbus_req   (dbus_req),
      .o_rd_bit     (rd_bit)
   );

   bus_arbiter bus_arbiter_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_req (ibus_req),
      .o_ibus_rsp (ibus_rsp),
      .i_dbus_req (dbus_req),
      .o_dbus_rsp (dbus_rsp),
      .o_mem_req  (o_mem_req),
      .i_mem_rsp  (i_mem_rsp)
   );

endmodule

`default_nettype wire

// ==== tests/tb_serv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "serv_config.svh"

module tb_serv_core
   import core_pkg::*, bus_pkg::*;
();

   localparam logic [6:0] OPC_IMM  = 7'b0010011;
   localparam logic [6:0] OPC_LOAD = 7'b0000011;

   typedef enum logic [1:0] {
      EXP_FETCH,
      EXP_LOAD,
      EXP_STORE
   } expect_e;

   logic        clk = 1'b0;
   logic        i_reset;
   mem_req_t    mem_req;
   mem_rsp_t    mem_rsp = '0;

   word_t       mem [256];
   word_t       ref_regs [32];
   expect_e     expect_kind = EXP_FETCH;
   word_t       exp_pc = `SERV_RESET_PC;
   word_t       exp_addr = '0;
   word_t       exp_data = '0;
   reg_addr_t   load_rd = '0;
   mem_req_t    held = '0;
   logic        busy = 1'b0;
   int          wait_left = 0;
   int          stores_done = 0;
   int          store_total = 0;
   int          prog_len = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   word_t       load_ptr;

   serv_core_top serv_core_top_i (
      .clk       (clk),
      .i_reset   (i_reset),
      .o_mem_req (mem_req),
      .i_mem_rsp (mem_rsp)
   );

   always #4 clk = ~clk;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("ERR %0t: %s", $time, msg));
   endtask

   function automatic logic [7:0] word_index(input word_t adr);
      return adr[9:2];
   endfunction

   function automatic word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic word_t encode_itype(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] opc);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
   endfunction

   function automatic word_t encode_rtype(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
   endfunction

   function automatic word_t encode_store(input int imm, input int rs2, input int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
   endfunction

   task automatic place_word(input word_t w);
      mem[word_index(load_ptr)] = w;
      load_ptr = load_ptr + 4;
      prog_len++;
   endtask

   task automatic place_store(input int imm, input int rs2, input int rs1);
      place_word(encode_store(imm, rs2, rs1));
      store_total++;
   endtask

   task automatic build_program();
      load_ptr = `SERV_RESET_PC;
      place_word(encode_itype(-5, 0, 3'b000, 1, OPC_IMM));
      place_word(encode_itype(1234, 0, 3'b000, 2, OPC_IMM));
      place_word(encode_itype(2047, 1, 3'b000, 3, OPC_IMM));
      place_word(encode_itype(-2048, 2, 3'b000, 4, OPC_IMM));
      place_word(encode_rtype(7'h00, 2, 1, 3'b000, 5));
      place_word(encode_rtype(7'h20, 2, 1, 3'b000, 6));
      place_word(encode_rtype(7'h20, 1, 2, 3'b000, 7));
      place_word(encode_rtype(7'h00, 4, 3, 3'b100, 8));
      place_word(encode_rtype(7'h00, 4, 1, 3'b110, 9));
      place_word(encode_rtype(7'h00, 3, 2, 3'b111, 10));
      place_word(encode_itype(-1, 5, 3'b100, 11, OPC_IMM));
      place_word(encode_itype(240, 6, 3'b110, 12, OPC_IMM));
      place_word(encode_itype(2047, 7, 3'b111, 13, OPC_IMM));
      place_word(encode_itype(-100, 8, 3'b111, 16, OPC_IMM));
      // Writes to x0 must vanish
      place_word(encode_itype(99, 1, 3'b000, 0, OPC_IMM));
      place_word(encode_rtype(7'h00, 3, 2, 3'b000, 0));
      // LUI is outside the subset, so x1 keeps its value
      place_word({20'h12345, 5'd1, 7'b0110111});
      place_word(encode_itype(512, 0, 3'b000, 20, OPC_IMM));
      place_word(encode_itype(768, 0, 3'b000, 21, OPC_IMM));
      for (int r = 1; r <= 13; r++) begin
         place_store((r - 1) * 4, r, 20);
      end
      place_store(52, 16, 20);
      place_store(-4, 0, 21);
      place_word(encode_itype(8, 20, 3'b010, 14, OPC_LOAD));
      place_word(encode_itype(128, 20, 3'b010, 15, OPC_LOAD));
      place_store(-8, 14, 21);
      place_store(-12, 15, 21);
      place_word(encode_rtype(7'h00, 15, 14, 3'b100, 17));
      place_store(-16, 17, 21);
      for (int k = 0; k < 4; k++) begin
         mem[word_index(load_ptr)] = 32'h0000_0013;
         load_ptr = load_ptr + 4;
      end
   endtask

   task automatic write_reg(input reg_addr_t rd, input word_t val);
      if (rd != 5'd0) begin
         ref_regs[rd] = val;
      end
   endtask

   // Reference ISA step for one fetched word
   task automatic apply_instr(input word_t instr);
      logic [6:0] opc;
      logic [2:0] f3;
      logic [6:0] f7;
      reg_addr_t  rd;
      word_t      a;
      word_t      b;
      word_t      imm_i;
      word_t      imm_s;
      opc   = instr[6:0];
      f3    = instr[14:12];
      f7    = instr[31:25];
      rd    = instr[11:7];
      a     = ref_regs[instr[19:15]];
      b     = ref_regs[instr[24:20]];
      imm_i = sext12(instr[31:20]);
      imm_s = sext12({instr[31:25], instr[11:7]});
      expect_kind = EXP_FETCH;
      case (opc)
         7'b0010011: begin
            case (f3)
               3'b000: write_reg(rd, a + imm_i);
               3'b100: write_reg(rd, a ^ imm_i);
               3'b110: write_reg(rd, a | imm_i);
               3'b111: write_reg(rd, a & imm_i);
               default: ;
            endcase
         end
         7'b0110011: begin
            if (f7 == 7'h00) begin
               case (f3)
                  3'b000: write_reg(rd, a + b);
                  3'b100: write_reg(rd, a ^ b);
                  3'b110: write_reg(rd, a | b);
                  3'b111: write_reg(rd, a & b);
                  default: ;
               endcase
            end else if ((f7 == 7'h20) && (f3 == 3'b000)) begin
               write_reg(rd, a - b);
            end
         end
         7'b0000011: begin
            if (f3 == 3'b010) begin
               expect_kind = EXP_LOAD;
               exp_addr    = (a + imm_i) & ~32'h3;
               load_rd     = rd;
            end
         end
         7'b0100011: begin
            if (f3 == 3'b010) begin
               expect_kind = EXP_STORE;
               exp_addr    = (a + imm_s) & ~32'h3;
               exp_data    = b;
            end
         end
         default: ;
      endcase
   endtask

   task automatic check_request(input mem_req_t req);
      case (expect_kind)
         EXP_FETCH: begin
            assert (!req.we && (req.adr == exp_pc))
               else report_mismatch($sformatf("fetch we=%0b adr=%h, expected read of %h",
                                              req.we, req.adr, exp_pc));
         end
         EXP_LOAD: begin
            assert (!req.we && (req.adr == exp_addr))
               else report_mismatch($sformatf("load we=%0b adr=%h, expected read of %h",
                                              req.we, req.adr, exp_addr));
         end
         default: begin
            assert (req.we && (req.adr == exp_addr) && (req.dat == exp_data))
               else report_mismatch($sformatf("store we=%0b adr=%h dat=%h, expected %h <= %h",
                                              req.we, req.adr, req.dat, exp_addr, exp_data));
         end
      endcase
   endtask

   task automatic complete_access();
      word_t rdt;
      rdt = '0;
      if (held.we) begin
         mem[word_index(held.adr)] = held.dat;
         stores_done++;
      end else begin
         rdt = mem[word_index(held.adr)];
      end
      if (expect_kind == EXP_FETCH) begin
         exp_pc = exp_pc + 4;
         apply_instr(rdt);
      end else begin
         if (expect_kind == EXP_LOAD) begin
            write_reg(load_rd, rdt);
         end
         expect_kind = EXP_FETCH;
      end
      mem_rsp.ack = 1'b1;
      mem_rsp.rdt = rdt;
   endtask

   // Memory model answering on the falling edge
   always @(negedge clk) begin
      if (i_reset) begin
         assert (!mem_req.cyc) else report_mismatch("cyc high while reset is active");
         busy = 1'b0;
      end else if (mem_rsp.ack) begin
         mem_rsp = '0;
         busy    = 1'b0;
         assert (!mem_req.cyc) else report_mismatch("cyc still high in the cycle after ack");
      end else if (mem_req.cyc) begin
         if (!busy) begin
            busy      = 1'b1;
            held      = mem_req;
            wait_left = $urandom % 4;
            check_request(held);
         end else begin
            assert (mem_req == held)
               else report_mismatch($sformatf("request changed before ack: %h, held %h",
                                              mem_req, held));
         end
         if (wait_left == 0) begin
            complete_access();
         end else begin
            wait_left--;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         abort_run($sformatf("Timeout after %0d cycles, the final store never came",
                             cycle_count));
      end
   end

   initial begin
      word_t adr;
      i_reset = 1'b1;
      void'($urandom(32'h0f752540));
      for (int i = 0; i < 256; i++) begin
         adr = i * 4;
         mem[word_index(adr)] = adr ^ 32'hc3a5_96e1;
      end
      ref_regs = '{default: '0};
      build_program();
      cycle_limit = 64 * prog_len + 200;
      repeat (2) @(posedge clk);
      @(negedge clk);
      i_reset = 1'b0;
      wait (stores_done == store_total);
      repeat (2) @(posedge clk);
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire
